//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_top
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
SIM_FLAGS  ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+dv
rtl/bladerunner_cfg_pkg.sv
rtl/axi4_bus_pkg.sv
rtl/reset_delay_pipe.sv
rtl/slot_rr_arbiter.sv
rtl/axi4_write_mux.sv
rtl/axi4_read_mux.sv
rtl/bladerunner_axi_top.sv
dv/tb_top.sv

//--- dv/tb_tasks.svh
// Directed tests for tb_top; they use its signals, memories and counters.
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// pattern covers the full word index
function automatic logic [511:0] fill_word(input int idx);
  return {16{32'hc0de_0000 | 32'(idx)}};
endfunction

function automatic logic [511:0] rand_word();
  logic [511:0] w;
  for (int i = 0; i < 16; i++) begin
    w[i*32 +: 32] = $random(seed);
  end
  return w;
endfunction

task automatic report_mismatch(input string sig, input logic [511:0] got,
                               input logic [511:0] exp);
  $display("Mismatch %s: got %h expected %h", sig, got, exp);
  errs++;
endtask

task automatic test_done(input string name, input int e0);
  if (errs == e0) begin
    pass_cnt++;
    $display("%s: clean", name);
  end else begin
    fail_cnt++;
    $display("%s: %0d errors", name, errs - e0);
  end
endtask

task automatic check_quiet();
  for (int s = 0; s < 2; s++) begin
    assert ({slot_miso[s].awready, slot_miso[s].wready, slot_miso[s].bvalid,
             slot_miso[s].arready, slot_miso[s].rvalid} == 5'b0)
      else report_mismatch($sformatf("slot%0d ready/valid", s), {slot_miso[s].awready,
        slot_miso[s].wready, slot_miso[s].bvalid, slot_miso[s].arready,
        slot_miso[s].rvalid}, 0);
  end
  assert ({ddr_mosi.awvalid, ddr_mosi.wvalid, ddr_mosi.bready, ddr_mosi.arvalid,
           ddr_mosi.rready} == 5'b0)
    else report_mismatch("ddr ready/valid", {ddr_mosi.awvalid, ddr_mosi.wvalid,
      ddr_mosi.bready, ddr_mosi.arvalid, ddr_mosi.rready}, 0);
endtask

// --------------------------------------------------
// per-slot drivers
// --------------------------------------------------
task automatic drive_write(input int s, input logic [5:0] id, input logic [63:0] addr,
                           input logic [511:0] data, output logic [5:0] bid);
  bit aw_done;
  bit w_done;
  bit b_done;
  aw_done = 0;
  w_done  = 0;
  b_done  = 0;
  @(negedge clk);
  slot_mosi[s].awid    <= id;
  slot_mosi[s].awaddr  <= addr;
  slot_mosi[s].awlen   <= '0;
  slot_mosi[s].awsize  <= 3'd6;
  slot_mosi[s].awburst <= 2'b01;
  slot_mosi[s].awvalid <= 1'b1;
  slot_mosi[s].wdata   <= data;
  slot_mosi[s].wstrb   <= '1;
  slot_mosi[s].wlast   <= 1'b1;
  slot_mosi[s].wvalid  <= 1'b1;
  slot_mosi[s].bready  <= 1'b1;
  while (!b_done) begin
    @(posedge clk);
    if (slot_mosi[s].awvalid && slot_miso[s].awready) aw_done = 1;
    if (slot_mosi[s].wvalid && slot_miso[s].wready) w_done = 1;
    if (slot_miso[s].bvalid && slot_mosi[s].bready) begin
      b_done = 1;
      bid    = slot_miso[s].bid;
    end
    @(negedge clk);
    if (aw_done) slot_mosi[s].awvalid <= 1'b0;
    if (w_done) slot_mosi[s].wvalid <= 1'b0;
    if (b_done) slot_mosi[s].bready <= 1'b0;
  end
endtask

// rready drops on beat stall_beat for stall_len cycles
task automatic drive_read(input int s, input logic [5:0] id, input logic [63:0] addr,
                          input int len, input int stall_beat, input int stall_len);
  int           beat;
  int           waited;
  int           idx;
  bit           ar_done;
  bit           held;
  logic [511:0] hold_data;
  beat    = 0;
  waited  = 0;
  ar_done = 0;
  held    = 0;
  idx     = int'(addr[9:6]);
  @(negedge clk);
  slot_mosi[s].arid    <= id;
  slot_mosi[s].araddr  <= addr;
  slot_mosi[s].arlen   <= 8'(len);
  slot_mosi[s].arsize  <= 3'd6;
  slot_mosi[s].arburst <= 2'b01;
  slot_mosi[s].arvalid <= 1'b1;
  slot_mosi[s].rready  <= !(stall_beat == 0 && stall_len > 0);
  while (beat <= len) begin
    @(posedge clk);
    if (slot_mosi[s].arvalid && slot_miso[s].arready) ar_done = 1;
    if (slot_miso[s].rvalid && !slot_mosi[s].rready) begin
      if (held) begin
        assert (slot_miso[s].rdata == hold_data)
          else report_mismatch("rdata while stalled", slot_miso[s].rdata, hold_data);
      end
      held      = 1;
      hold_data = slot_miso[s].rdata;
      waited++;
    end
    if (slot_miso[s].rvalid && slot_mosi[s].rready) begin
      assert (slot_miso[s].rid == id) else report_mismatch("rid", slot_miso[s].rid, id);
      assert (slot_miso[s].rdata == exp_mem[(idx + beat) % 16])
        else report_mismatch("rdata", slot_miso[s].rdata, exp_mem[(idx + beat) % 16]);
      assert (slot_miso[s].rlast == (beat == len))
        else report_mismatch("rlast", slot_miso[s].rlast, beat == len);
      beat++;
      held = 0;
    end
    @(negedge clk);
    if (ar_done) slot_mosi[s].arvalid <= 1'b0;
    slot_mosi[s].rready <= !(beat == stall_beat && waited < stall_len);
  end
  slot_mosi[s].rready <= 1'b0;
endtask

// --------------------------------------------------
// directed tests
// --------------------------------------------------
task automatic reset_test();
  int e0;
  e0 = errs;
  // requests pending through reset must not leak out
  for (int s = 0; s < 2; s++) begin
    slot_mosi[s].awvalid = 1'b1;
    slot_mosi[s].wvalid  = 1'b1;
    slot_mosi[s].bready  = 1'b1;
    slot_mosi[s].arvalid = 1'b1;
    slot_mosi[s].rready  = 1'b1;
  end
  repeat (8) begin
    @(posedge clk);
    check_quiet();
  end
  @(negedge clk);
  rst_n <= 1'b1;
  repeat (4) begin
    @(posedge clk);
    check_quiet();
  end
  @(negedge clk);
  slot_mosi <= '0;
  test_done("reset", e0);
endtask

task automatic single_write_test();
  int           e0;
  int           b0;
  logic [511:0] data;
  logic [5:0]   bid;
  e0   = errs;
  b0   = b_cnt[0];
  data = rand_word();
  drive_write(1, 6'h15, 64'h0000_0000_8000_00c0, data, bid);
  exp_mem[3] = data;
  assert (cap_awid == 6'h15) else report_mismatch("awid", cap_awid, 6'h15);
  assert (cap_awaddr == 64'h8000_00c0) else report_mismatch("awaddr", cap_awaddr, 64'h8000_00c0);
  assert (cap_awlen == 8'd0) else report_mismatch("awlen", cap_awlen, 0);
  assert (cap_awsize == 3'd6) else report_mismatch("awsize", cap_awsize, 3'd6);
  assert (cap_awburst == 2'b01) else report_mismatch("awburst", cap_awburst, 2'b01);
  assert (cap_wdata == data) else report_mismatch("wdata", cap_wdata, data);
  assert (cap_wstrb == '1) else report_mismatch("wstrb", cap_wstrb, {64{1'b1}});
  assert (bid == 6'h15) else report_mismatch("bid", bid, 6'h15);
  assert (b_cnt[0] == b0) else report_mismatch("slot0 b count", b_cnt[0], b0);
  wr_last = 1;
  drive_read(0, 6'h21, 64'h0000_0000_8000_00c0, 0, -1, 0);
  test_done("single write", e0);
endtask

task automatic burst_read_test();
  int e0;
  e0 = errs;
  drive_read(0, 6'h0a, 64'h100, 3, -1, 0);
  assert (cap_arsize == 3'd6) else report_mismatch("arsize", cap_arsize, 3'd6);
  assert (cap_arburst == 2'b01) else report_mismatch("arburst", cap_arburst, 2'b01);
  test_done("burst read", e0);
endtask

task automatic contend_write_test();
  int           e0;
  int           first;
  logic [511:0] d0;
  logic [511:0] d1;
  logic [5:0]   bid0;
  logic [5:0]   bid1;
  e0 = errs;
  for (int r = 0; r < 2; r++) begin
    d0    = rand_word();
    d1    = rand_word();
    first = 1 - wr_last;
    b_order.delete();
    fork
      drive_write(0, 6'h30, 64'((8 + 2 * r) * 64), d0, bid0);
      drive_write(1, 6'h31, 64'((9 + 2 * r) * 64), d1, bid1);
    join
    exp_mem[8 + 2 * r] = d0;
    exp_mem[9 + 2 * r] = d1;
    assert (bid0 == 6'h30) else report_mismatch("slot0 bid", bid0, 6'h30);
    assert (bid1 == 6'h31) else report_mismatch("slot1 bid", bid1, 6'h31);
    assert (b_order.size() == 2 && b_order[0] == first)
      else begin
        $display("Write grant order wrong in round %0d, slot %0d should go first", r, first);
        errs++;
      end
    wr_last = 1 - first;
  end
  test_done("contending writes", e0);
endtask

task automatic split_dir_test();
  int           e0;
  int           t0;
  int           rd_end;
  int           wr_end;
  logic [511:0] data;
  logic [5:0]   bid;
  e0   = errs;
  t0   = cyc;
  data = rand_word();
  fork
    begin
      drive_read(0, 6'h11, 64'h140, 0, -1, 0);
      rd_end = cyc;
    end
    begin
      drive_write(1, 6'h12, 64'h300, data, bid);
      wr_end = cyc;
    end
  join
  exp_mem[12] = data;
  assert (bid == 6'h12) else report_mismatch("bid", bid, 6'h12);
  // alone the read ends 4 cycles after t0 and the write 5, one after the other takes 8
  assert (rd_end - t0 <= 5 && wr_end - t0 <= 5)
    else begin
      $display("Read and write did not overlap, took %0d and %0d cycles",
               rd_end - t0, wr_end - t0);
      errs++;
    end
  test_done("independent directions", e0);
endtask

task automatic backpressure_test();
  int e0;
  e0 = errs;
  fork
    drive_read(1, 6'h2c, 64'h180, 3, 1, 4);
    begin
      repeat (2) @(negedge clk);
      drive_read(0, 6'h2d, 64'h200, 0, -1, 0);
    end
  join
  assert (ar_fwd_id == 6'h2d) else report_mismatch("ddr arid", ar_fwd_id, 6'h2d);
  assert (ar_fwd_cyc > rlast_cyc[1])
    else begin
      $display("Slot 0 read reached DDR before slot 1 took its last beat");
      errs++;
    end
  test_done("back-pressure", e0);
endtask

`endif

//--- dv/tb_top.sv
// DDR model answers with fixed latency; 16 words of 64 bytes at address bits 9:6.
// Writes from the tests are single beat, reads may be bursts.
`default_nettype none
`timescale 1ns/1ns

module tb_top;

  localparam int max_cycles_lp = 2000;

  logic clk = 1'b0;
  logic rst_n;
  axi4_bus_pkg::axi4_mosi_vec_t slot_mosi;
  axi4_bus_pkg::axi4_miso_vec_t slot_miso;
  axi4_bus_pkg::axi4_mosi_s     ddr_mosi;
  axi4_bus_pkg::axi4_miso_s     ddr_miso;

  logic [511:0] mem [16];
  logic [511:0] exp_mem [16];
  logic         aw_have, b_pend, ar_have;
  logic [5:0]   aw_id, ar_id, cap_awid, ar_fwd_id;
  logic [3:0]   aw_idx, ar_idx;
  logic [7:0]   w_beat, ar_len, r_beat, cap_awlen;
  logic [2:0]   cap_awsize, cap_arsize;
  logic [1:0]   cap_awburst, cap_arburst;
  logic [63:0]  cap_awaddr;
  logic [511:0] cap_wdata;
  logic [63:0]  cap_wstrb;
  int           cyc = 0;
  int           ar_fwd_cyc, errs, pass_cnt, fail_cnt, wr_last;
  int           b_cnt [2];
  int           rlast_cyc [2];
  int           b_order [$];
  integer       seed;

  always #5 clk = ~clk;

  bladerunner_axi_top i_dut (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .slot_mosi_i(slot_mosi),
    .slot_miso_o(slot_miso),
    .ddr_mosi_o (ddr_mosi),
    .ddr_miso_i (ddr_miso)
  );

  `include "tb_tasks.svh"

  // --------------------------------------------------
  // ddr responder, state on rising edge
  // --------------------------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      aw_have <= 1'b0;
      b_pend  <= 1'b0;
      ar_have <= 1'b0;
    end else begin
      if (ddr_mosi.awvalid && ddr_miso.awready) begin
        aw_have     <= 1'b1;
        aw_id       <= ddr_mosi.awid;
        aw_idx      <= ddr_mosi.awaddr[9:6];
        w_beat      <= '0;
        cap_awid    <= ddr_mosi.awid;
        cap_awaddr  <= ddr_mosi.awaddr;
        cap_awlen   <= ddr_mosi.awlen;
        cap_awsize  <= ddr_mosi.awsize;
        cap_awburst <= ddr_mosi.awburst;
      end
      if (ddr_mosi.wvalid && ddr_miso.wready) begin
        mem[4'(aw_idx + w_beat)] <= ddr_mosi.wdata;
        w_beat    <= w_beat + 8'd1;
        cap_wdata <= ddr_mosi.wdata;
        cap_wstrb <= ddr_mosi.wstrb;
        if (ddr_mosi.wlast) b_pend <= 1'b1;
      end
      if (ddr_miso.bvalid && ddr_mosi.bready) begin
        b_pend  <= 1'b0;
        aw_have <= 1'b0;
      end
      if (ddr_mosi.arvalid && ddr_miso.arready) begin
        ar_have     <= 1'b1;
        ar_id       <= ddr_mosi.arid;
        ar_idx      <= ddr_mosi.araddr[9:6];
        ar_len      <= ddr_mosi.arlen;
        r_beat      <= '0;
        cap_arsize  <= ddr_mosi.arsize;
        cap_arburst <= ddr_mosi.arburst;
      end
      if (ddr_miso.rvalid && ddr_mosi.rready) begin
        if (ddr_miso.rlast) ar_have <= 1'b0;
        else r_beat <= r_beat + 8'd1;
      end
    end
  end

  // outputs move on the falling edge like every other dut input
  always @(negedge clk) begin : ddr_drive
    axi4_bus_pkg::axi4_miso_s nxt;
    nxt         = '0;
    nxt.awready = !aw_have;
    nxt.wready  = aw_have && !b_pend;
    nxt.bvalid  = b_pend;
    nxt.bid     = aw_id;
    nxt.arready = !ar_have;
    nxt.rvalid  = ar_have;
    nxt.rid     = ar_id;
    nxt.rdata   = mem[4'(ar_idx + r_beat)];
    nxt.rlast   = (r_beat == ar_len);
    ddr_miso <= nxt;
  end

  // completion log and run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    for (int s = 0; s < 2; s++) begin
      // any bvalid counts, even one the slot does not accept
      if (slot_miso[s].bvalid) begin
        b_cnt[s]++;
      end
      if (slot_miso[s].bvalid && slot_mosi[s].bready) begin
        b_order.push_back(s);
      end
      if (slot_miso[s].rvalid && slot_mosi[s].rready && slot_miso[s].rlast) rlast_cyc[s] = cyc;
    end
    if (ddr_mosi.arvalid && ddr_miso.arready) begin
      ar_fwd_id  <= ddr_mosi.arid;
      ar_fwd_cyc <= cyc;
    end
    if (cyc >= max_cycles_lp) begin
      $display("Timeout: run stopped after %0d cycles", cyc);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    seed      = 32'h1e1f;
    rst_n     = 1'b0;
    slot_mosi = '0;
    ddr_miso  = '0;
    errs      = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    b_cnt     = '{0, 0};
    rlast_cyc = '{0, 0};
    for (int i = 0; i < 16; i++) begin
      mem[i]     = fill_word(i);
      exp_mem[i] = fill_word(i);
    end
    reset_test();
    single_write_test();
    burst_read_test();
    contend_write_test();
    split_dir_test();
    backpressure_test();
    $display("Summary: %0d tests clean, %0d tests with errors", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/axi4_bus_pkg.sv
// AXI4 bus structs without lock, cache, prot, qos and region fields.
`default_nettype none

package axi4_bus_pkg;

  // --------------------------------------------------
  // master to slave
  // --------------------------------------------------
  typedef struct packed {
    logic [bladerunner_cfg_pkg::axi_id_width_lp-1:0]    awid;
    logic [bladerunner_cfg_pkg::axi_addr_width_lp-1:0]  awaddr;
    logic [bladerunner_cfg_pkg::axi_len_width_lp-1:0]   awlen;
    logic [bladerunner_cfg_pkg::axi_size_width_lp-1:0]  awsize;
    logic [bladerunner_cfg_pkg::axi_burst_width_lp-1:0] awburst;
    logic                                               awvalid;
    logic [bladerunner_cfg_pkg::axi_data_width_lp-1:0]  wdata;
    logic [bladerunner_cfg_pkg::axi_strb_width_lp-1:0]  wstrb;
    logic                                               wlast;
    logic                                               wvalid;
    logic                                               bready;
    logic [bladerunner_cfg_pkg::axi_id_width_lp-1:0]    arid;
    logic [bladerunner_cfg_pkg::axi_addr_width_lp-1:0]  araddr;
    logic [bladerunner_cfg_pkg::axi_len_width_lp-1:0]   arlen;
    logic [bladerunner_cfg_pkg::axi_size_width_lp-1:0]  arsize;
    logic [bladerunner_cfg_pkg::axi_burst_width_lp-1:0] arburst;
    logic                                               arvalid;
    logic                                               rready;
  } axi4_mosi_s;

  // --------------------------------------------------
  // slave to master
  // --------------------------------------------------
  typedef struct packed {
    logic                                              awready;
    logic                                              wready;
    logic [bladerunner_cfg_pkg::axi_id_width_lp-1:0]   bid;
    logic [bladerunner_cfg_pkg::axi_resp_width_lp-1:0] bresp;
    logic                                              bvalid;
    logic                                              arready;
    logic [bladerunner_cfg_pkg::axi_id_width_lp-1:0]   rid;
    logic [bladerunner_cfg_pkg::axi_data_width_lp-1:0] rdata;
    logic [bladerunner_cfg_pkg::axi_resp_width_lp-1:0] rresp;
    logic                                              rlast;
    logic                                              rvalid;
  } axi4_miso_s;

  // slot side, index 0 is pcis
  typedef axi4_mosi_s [bladerunner_cfg_pkg::slot_num_lp-1:0] axi4_mosi_vec_t;
  typedef axi4_miso_s [bladerunner_cfg_pkg::slot_num_lp-1:0] axi4_miso_vec_t;

endpackage

`default_nettype wire

//--- rtl/axi4_read_mux.sv
// One read burst in flight; AW, W and B fields are driven to zero here.
`default_nettype none
`timescale 1ns/1ns

module axi4_read_mux (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  axi4_bus_pkg::axi4_mosi_vec_t slot_mosi_i,
  output axi4_bus_pkg::axi4_miso_vec_t slot_miso_o,
  output axi4_bus_pkg::axi4_mosi_s     ddr_mosi_o,
  input  axi4_bus_pkg::axi4_miso_s     ddr_miso_i
);

  logic [bladerunner_cfg_pkg::slot_num_lp-1:0]       ar_req;
  logic [bladerunner_cfg_pkg::slot_num_lp-1:0]       grant;
  logic [bladerunner_cfg_pkg::slot_sel_width_lp-1:0] grant_idx;
  logic                                              busy;
  logic                                              ar_sent_r;
  logic                                              r_done;
  axi4_bus_pkg::axi4_mosi_s                          sel_mosi;

  always_comb begin
    for (int s = 0; s < bladerunner_cfg_pkg::slot_num_lp; s++) begin
      ar_req[s] = slot_mosi_i[s].arvalid;
    end
  end

  slot_rr_arbiter i_arb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (ar_req),
    .release_i  (r_done),
    .grant_o    (grant),
    .grant_idx_o(grant_idx),
    .busy_o     (busy)
  );

  assign sel_mosi = slot_mosi_i[grant_idx];
  // burst ends on the rlast handshake
  assign r_done   = busy & ddr_miso_i.rvalid & ddr_miso_i.rlast & sel_mosi.rready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ar_sent_r <= 1'b0;
    end else if (r_done) begin
      ar_sent_r <= 1'b0;
    end else if (ddr_mosi_o.arvalid && ddr_miso_i.arready) begin
      ar_sent_r <= 1'b1;
    end
  end

  // --------------------------------------------------
  // steering
  // --------------------------------------------------
  always_comb begin
    ddr_mosi_o         = '0;
    ddr_mosi_o.arid    = sel_mosi.arid;
    ddr_mosi_o.araddr  = sel_mosi.araddr;
    ddr_mosi_o.arlen   = sel_mosi.arlen;
    ddr_mosi_o.arsize  = sel_mosi.arsize;
    ddr_mosi_o.arburst = sel_mosi.arburst;
    ddr_mosi_o.arvalid = busy & sel_mosi.arvalid & ~ar_sent_r;
    ddr_mosi_o.rready  = busy & sel_mosi.rready;
  end

  always_comb begin
    for (int s = 0; s < bladerunner_cfg_pkg::slot_num_lp; s++) begin
      slot_miso_o[s]         = '0;
      slot_miso_o[s].arready = grant[s] & ddr_miso_i.arready & ~ar_sent_r;
      slot_miso_o[s].rid     = ddr_miso_i.rid;
      slot_miso_o[s].rdata   = ddr_miso_i.rdata;
      slot_miso_o[s].rresp   = ddr_miso_i.rresp;
      slot_miso_o[s].rlast   = ddr_miso_i.rlast;
      slot_miso_o[s].rvalid  = grant[s] & ddr_miso_i.rvalid;
    end
  end

endmodule

`default_nettype wire

//--- rtl/axi4_write_mux.sv
// One write transaction in flight; AR and R fields are driven to zero here.
`default_nettype none
`timescale 1ns/1ns

module axi4_write_mux (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  axi4_bus_pkg::axi4_mosi_vec_t slot_mosi_i,
  output axi4_bus_pkg::axi4_miso_vec_t slot_miso_o,
  output axi4_bus_pkg::axi4_mosi_s     ddr_mosi_o,
  input  axi4_bus_pkg::axi4_miso_s     ddr_miso_i
);

  logic [bladerunner_cfg_pkg::slot_num_lp-1:0]       aw_req;
  logic [bladerunner_cfg_pkg::slot_num_lp-1:0]       grant;
  logic [bladerunner_cfg_pkg::slot_sel_width_lp-1:0] grant_idx;
  logic                                              busy;
  logic                                              aw_sent_r;
  logic                                              b_done;
  axi4_bus_pkg::axi4_mosi_s                          sel_mosi;

  always_comb begin
    for (int s = 0; s < bladerunner_cfg_pkg::slot_num_lp; s++) begin
      aw_req[s] = slot_mosi_i[s].awvalid;
    end
  end

  slot_rr_arbiter i_arb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (aw_req),
    .release_i  (b_done),
    .grant_o    (grant),
    .grant_idx_o(grant_idx),
    .busy_o     (busy)
  );

  assign sel_mosi = slot_mosi_i[grant_idx];
  assign b_done   = busy & ddr_miso_i.bvalid & sel_mosi.bready;

  // address goes out once per grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      aw_sent_r <= 1'b0;
    end else if (b_done) begin
      aw_sent_r <= 1'b0;
    end else if (ddr_mosi_o.awvalid && ddr_miso_i.awready) begin
      aw_sent_r <= 1'b1;
    end
  end

  // --------------------------------------------------
  // steering
  // --------------------------------------------------
  always_comb begin
    ddr_mosi_o         = '0;
    ddr_mosi_o.awid    = sel_mosi.awid;
    ddr_mosi_o.awaddr  = sel_mosi.awaddr;
    ddr_mosi_o.awlen   = sel_mosi.awlen;
    ddr_mosi_o.awsize  = sel_mosi.awsize;
    ddr_mosi_o.awburst = sel_mosi.awburst;
    ddr_mosi_o.awvalid = busy & sel_mosi.awvalid & ~aw_sent_r;
    ddr_mosi_o.wdata   = sel_mosi.wdata;
    ddr_mosi_o.wstrb   = sel_mosi.wstrb;
    ddr_mosi_o.wlast   = sel_mosi.wlast;
    ddr_mosi_o.wvalid  = busy & sel_mosi.wvalid;
    ddr_mosi_o.bready  = busy & sel_mosi.bready;
  end

  // losing slot sees every ready and valid low
  always_comb begin
    for (int s = 0; s < bladerunner_cfg_pkg::slot_num_lp; s++) begin
      slot_miso_o[s]         = '0;
      slot_miso_o[s].awready = grant[s] & ddr_miso_i.awready & ~aw_sent_r;
      slot_miso_o[s].wready  = grant[s] & ddr_miso_i.wready;
      slot_miso_o[s].bid     = ddr_miso_i.bid;
      slot_miso_o[s].bresp   = ddr_miso_i.bresp;
      slot_miso_o[s].bvalid  = grant[s] & ddr_miso_i.bvalid;
    end
  end

endmodule

`default_nettype wire

//--- rtl/bladerunner_axi_top.sv
// Two AXI4 masters share one DDR port; slot 0 is pcis, slot 1 the cache side.
// Reads and writes are arbitrated separately, one transaction per direction.
`default_nettype none
`timescale 1ns/1ns

module bladerunner_axi_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  axi4_bus_pkg::axi4_mosi_vec_t slot_mosi_i,
  output axi4_bus_pkg::axi4_miso_vec_t slot_miso_o,
  output axi4_bus_pkg::axi4_mosi_s     ddr_mosi_o,
  input  axi4_bus_pkg::axi4_miso_s     ddr_miso_i
);

  logic                         mux_rst_n;
  axi4_bus_pkg::axi4_mosi_s     wr_ddr_mosi;
  axi4_bus_pkg::axi4_mosi_s     rd_ddr_mosi;
  axi4_bus_pkg::axi4_miso_vec_t wr_slot_miso;
  axi4_bus_pkg::axi4_miso_vec_t rd_slot_miso;

  // muxes stay idle until the masters have settled
  reset_delay_pipe i_mux_rst (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .rst_n_o(mux_rst_n)
  );

  axi4_write_mux i_write_mux (
    .clk_i      (clk_i),
    .rst_n_i    (mux_rst_n),
    .slot_mosi_i(slot_mosi_i),
    .slot_miso_o(wr_slot_miso),
    .ddr_mosi_o (wr_ddr_mosi),
    .ddr_miso_i (ddr_miso_i)
  );

  axi4_read_mux i_read_mux (
    .clk_i      (clk_i),
    .rst_n_i    (mux_rst_n),
    .slot_mosi_i(slot_mosi_i),
    .slot_miso_o(rd_slot_miso),
    .ddr_mosi_o (rd_ddr_mosi),
    .ddr_miso_i (ddr_miso_i)
  );

  // each half is zero outside its own channel fields
  assign ddr_mosi_o  = wr_ddr_mosi | rd_ddr_mosi;
  assign slot_miso_o = wr_slot_miso | rd_slot_miso;

endmodule

`default_nettype wire

//--- rtl/bladerunner_cfg_pkg.sv
// AXI4 widths and slot count for the shared DDR port, fixed at build time.
// The slot count is assumed to be a power of two that fits slot_sel_width_lp.
`default_nettype none

package bladerunner_cfg_pkg;

  // masters on the ddr port, slot 0 is pcis and slot 1 the cache side
  localparam int slot_num_lp       = 2;
  localparam int slot_sel_width_lp = 1;

  // --------------------------------------------------
  // axi4 field widths
  // --------------------------------------------------
  localparam int axi_id_width_lp    = 6;
  localparam int axi_addr_width_lp  = 64;
  localparam int axi_data_width_lp  = 512;
  localparam int axi_strb_width_lp  = axi_data_width_lp / 8;
  localparam int axi_len_width_lp   = 8;
  localparam int axi_size_width_lp  = 3;
  localparam int axi_burst_width_lp = 2;
  localparam int axi_resp_width_lp  = 2;

  // cycles between rst_n_i release and mux release
  localparam int reset_stages_lp = 4;

endpackage

`default_nettype wire

//--- rtl/reset_delay_pipe.sv
// Release of rst_n_o lags rst_n_i by reset_stages_lp cycles; assertion is seen
// on the next clock edge.
`default_nettype none
`timescale 1ns/1ns

module reset_delay_pipe (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic rst_n_o
);

  logic [bladerunner_cfg_pkg::reset_stages_lp-1:0] stage_r;

  // zeros while held, ones walk in after release
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stage_r <= '0;
    end else begin
      stage_r <= {stage_r[bladerunner_cfg_pkg::reset_stages_lp-2:0], 1'b1};
    end
  end

  assign rst_n_o = stage_r[bladerunner_cfg_pkg::reset_stages_lp-1];

endmodule

`default_nettype wire

//--- rtl/slot_rr_arbiter.sv
// Round-robin grant for one transaction at a time; grant holds until release_i.
// Slot count must be a power of two so the pointer reset gives slot 0 priority.
`default_nettype none
`timescale 1ns/1ns

module slot_rr_arbiter (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  logic [bladerunner_cfg_pkg::slot_num_lp-1:0]       req_i,
  input  logic                                              release_i,
  output logic [bladerunner_cfg_pkg::slot_num_lp-1:0]       grant_o,
  output logic [bladerunner_cfg_pkg::slot_sel_width_lp-1:0] grant_idx_o,
  output logic                                              busy_o
);

  logic                                              busy_r;
  logic [bladerunner_cfg_pkg::slot_sel_width_lp-1:0] grant_idx_r;
  logic [bladerunner_cfg_pkg::slot_sel_width_lp-1:0] last_r;
  logic [bladerunner_cfg_pkg::slot_sel_width_lp-1:0] pick_idx;
  logic                                              pick_v;

  // first requester after the last winner
  always_comb begin
    int cand;
    pick_v   = 1'b0;
    pick_idx = '0;
    for (int i = 1; i <= bladerunner_cfg_pkg::slot_num_lp; i++) begin
      cand = (int'(last_r) + i) % bladerunner_cfg_pkg::slot_num_lp;
      if (!pick_v && req_i[cand]) begin
        pick_v   = 1'b1;
        pick_idx = cand[bladerunner_cfg_pkg::slot_sel_width_lp-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_r      <= 1'b0;
      grant_idx_r <= '0;
      last_r      <= '1;
    end else if (busy_r) begin
      if (release_i) begin
        busy_r <= 1'b0;
      end
    end else if (pick_v) begin
      busy_r      <= 1'b1;
      grant_idx_r <= pick_idx;
      last_r      <= pick_idx;
    end
  end

  assign grant_o = busy_r
                 ? {{(bladerunner_cfg_pkg::slot_num_lp-1){1'b0}}, 1'b1} << grant_idx_r
                 : '0;
  assign grant_idx_o = grant_idx_r;
  assign busy_o      = busy_r;

endmodule

`default_nettype wire
